/* rtl/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // ALU operations, AluAdd must stay zero so a bubble decodes harmlessly
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluLui
    } aluOpT;

    typedef enum logic [1:0] {
        FwdReg = 2'd0,
        FwdWb  = 2'd1,
        FwdMem = 2'd2
    } fwdSelT;

    // primary opcodes
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpLui     = 6'h0f;
    localparam logic [5:0] OpLw      = 6'h23;
    localparam logic [5:0] OpSw      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnXor  = 6'h26;
    localparam logic [5:0] FnSlt  = 6'h2a;

    typedef struct packed {
        wordT inst;
        wordT pc;
    } ifIdT;

    typedef struct packed {
        wordT    rsData;
        wordT    rtData;
        wordT    imm;
        regAddrT rs;
        regAddrT rt;
        regAddrT destReg;
        aluOpT   aluOp;
        logic    aluSrcImm;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        wordT    pc;
    } idExT;

    typedef struct packed {
        wordT    aluResult;
        wordT    storeData;
        regAddrT destReg;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        wordT    pc;
    } exMemT;

    typedef struct packed {
        wordT    wbData;
        regAddrT destReg;
        logic    regWrite;
        wordT    pc;
    } memWbT;

endpackage

/* rtl/stageReg.sv */
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    enable,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // an all-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

/* rtl/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder (
    input  mipsPkg::wordT    inst,
    output mipsPkg::regAddrT rs,
    output mipsPkg::regAddrT rt,
    output mipsPkg::regAddrT destReg,
    output mipsPkg::wordT    imm,
    output mipsPkg::aluOpT   aluOp,
    output logic             aluSrcImm,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       writesReg;
    logic       signExt;
    logic       useRd;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];

    always_comb begin
        aluOp     = AluAdd;
        aluSrcImm = 1'b0;
        writesReg = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        signExt   = 1'b0;
        useRd     = 1'b0;
        case (opcode)
            OpSpecial: begin
                useRd     = 1'b1;
                writesReg = 1'b1;
                case (funct)
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnSlt:   aluOp = AluSlt;
                    default: writesReg = 1'b0;
                endcase
            end
            OpAddiu: begin
                aluSrcImm = 1'b1;
                writesReg = 1'b1;
                signExt   = 1'b1;
            end
            OpOri: begin
                aluOp     = AluOr;
                aluSrcImm = 1'b1;
                writesReg = 1'b1;
            end
            OpLui: begin
                aluOp     = AluLui;
                aluSrcImm = 1'b1;
                writesReg = 1'b1;
            end
            OpLw: begin
                aluSrcImm = 1'b1;
                writesReg = 1'b1;
                memRead   = 1'b1;
                signExt   = 1'b1;
            end
            OpSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                signExt   = 1'b1;
            end
            default: ;
        endcase
    end

    assign destReg  = useRd ? inst[15:11] : inst[20:16];
    // $0 is never a real destination
    assign regWrite = writesReg && (destReg != '0);
    assign imm      = {{16{signExt & inst[15]}}, inst[15:0]};

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  logic             writeEn,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT    writeData,
    input  mipsPkg::regAddrT readAddrA,
    input  mipsPkg::regAddrT readAddrB,
    output mipsPkg::wordT    readDataA,
    output mipsPkg::wordT    readDataB
);
    import mipsPkg::*;

    wordT regs [1:31];
    logic bypassA;
    logic bypassB;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle write shows up on the read ports
    assign bypassA = writeEn && (writeAddr == readAddrA);
    assign bypassB = writeEn && (writeAddr == readAddrB);

    assign readDataA = (readAddrA == '0) ? '0 : (bypassA ? writeData : regs[readAddrA]);
    assign readDataB = (readAddrB == '0) ? '0 : (bypassB ? writeData : regs[readAddrB]);

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::regAddrT rsD,
    input  mipsPkg::regAddrT rtD,
    input  mipsPkg::regAddrT rsE,
    input  mipsPkg::regAddrT rtE,
    input  mipsPkg::regAddrT destE,
    input  logic             memReadE,
    input  mipsPkg::regAddrT destM,
    input  logic             regWriteM,
    input  mipsPkg::regAddrT destW,
    input  logic             regWriteW,
    input  logic             stallAll,
    output logic             loadUseStall,
    output logic             flushE,
    output mipsPkg::fwdSelT  forwardA,
    output mipsPkg::fwdSelT  forwardB
);
    import mipsPkg::*;

    // memory stage is younger, so it wins over writeback
    function automatic fwdSelT pickForward(input regAddrT src);
        if (regWriteM && destM != '0 && destM == src) begin
            return FwdMem;
        end else if (regWriteW && destW != '0 && destW == src) begin
            return FwdWb;
        end
        return FwdReg;
    endfunction

    assign forwardA = pickForward(rsE);
    assign forwardB = pickForward(rtE);

    // load result not ready until after memory stage
    assign loadUseStall = memReadE && (destE != '0) &&
                          ((destE == rsD) || (destE == rtD));

    // the bubble is only inserted when the pipe actually moves
    assign flushE = loadUseStall && !stallAll;

endmodule

/* rtl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  mipsPkg::aluOpT op,
    input  mipsPkg::wordT  srcA,
    input  mipsPkg::wordT  srcB,
    output mipsPkg::wordT  result
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            AluAdd:  result = srcA + srcB;
            AluSub:  result = srcA - srcB;
            AluAnd:  result = srcA & srcB;
            AluOr:   result = srcA | srcB;
            AluXor:  result = srcA ^ srcB;
            AluSlt:  result = {31'b0, $signed(srcA) < $signed(srcB)};
            // immediate arrives zero-extended in srcB
            AluLui:  result = {srcB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

/* rtl/pipeCore.sv */
`timescale 1ns/1ps

module pipeCore #(
    parameter mipsPkg::wordT ResetPc = 32'hbfc00000
) (
    input  logic             clk,
    input  logic             reset,

    // instruction side
    output mipsPkg::wordT    pc,
    output logic             instEn,
    input  mipsPkg::wordT    inst,
    input  logic             iStall,

    // data side
    output mipsPkg::wordT    addr,
    output mipsPkg::wordT    writeData,
    input  mipsPkg::wordT    readData,
    output logic [3:0]       memWen,
    output logic             memEn,
    input  logic             dStall,

    output logic             stallAll,

    // debug
    output mipsPkg::wordT    debugWbPc,
    output logic [3:0]       debugWbRfWen,
    output mipsPkg::regAddrT debugWbRfWnum,
    output mipsPkg::wordT    debugWbRfWdata
);
    import mipsPkg::*;

    ifIdT  ifIdIn, ifId;
    idExT  idExIn, idEx;
    exMemT exMemIn, exMem;
    memWbT memWbIn, memWb;

    logic    frontEnable;
    logic    loadUseStall;
    logic    flushE;
    fwdSelT  forwardA;
    fwdSelT  forwardB;
    regAddrT rsD;
    regAddrT rtD;
    wordT    srcA;
    wordT    srcBReg;
    wordT    srcB;
    logic    rfWriteEn;

    assign stallAll    = iStall | dStall;
    assign frontEnable = !(stallAll || loadUseStall);

    // fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= ResetPc;
        end else if (frontEnable) begin
            pc <= pc + 32'd4;
        end
    end

    // no redirects, so fetch runs every cycle
    assign instEn = 1'b1;

    assign ifIdIn.inst = inst;
    assign ifIdIn.pc   = pc;

    stageReg #(.payloadT(ifIdT)) ifIdReg (
        .clk    (clk),
        .reset  (reset),
        .enable (frontEnable),
        .flush  (1'b0),
        .d      (ifIdIn),
        .q      (ifId)
    );

    // decode
    instDecoder decoder0 (
        .inst      (ifId.inst),
        .rs        (rsD),
        .rt        (rtD),
        .destReg   (idExIn.destReg),
        .imm       (idExIn.imm),
        .aluOp     (idExIn.aluOp),
        .aluSrcImm (idExIn.aluSrcImm),
        .regWrite  (idExIn.regWrite),
        .memRead   (idExIn.memRead),
        .memWrite  (idExIn.memWrite)
    );

    assign rfWriteEn = memWb.regWrite && !stallAll;

    regFile regFile0 (
        .clk       (clk),
        .reset     (reset),
        .writeEn   (rfWriteEn),
        .writeAddr (memWb.destReg),
        .writeData (memWb.wbData),
        .readAddrA (rsD),
        .readAddrB (rtD),
        .readDataA (idExIn.rsData),
        .readDataB (idExIn.rtData)
    );

    assign idExIn.rs = rsD;
    assign idExIn.rt = rtD;
    assign idExIn.pc = ifId.pc;

    hazardUnit hazard0 (
        .rsD          (rsD),
        .rtD          (rtD),
        .rsE          (idEx.rs),
        .rtE          (idEx.rt),
        .destE        (idEx.destReg),
        .memReadE     (idEx.memRead),
        .destM        (exMem.destReg),
        .regWriteM    (exMem.regWrite),
        .destW        (memWb.destReg),
        .regWriteW    (memWb.regWrite),
        .stallAll     (stallAll),
        .loadUseStall (loadUseStall),
        .flushE       (flushE),
        .forwardA     (forwardA),
        .forwardB     (forwardB)
    );

    stageReg #(.payloadT(idExT)) idExReg (
        .clk    (clk),
        .reset  (reset),
        .enable (!stallAll),
        .flush  (flushE),
        .d      (idExIn),
        .q      (idEx)
    );

    // execute, operand forwarding
    always_comb begin
        case (forwardA)
            FwdMem:  srcA = exMem.aluResult;
            FwdWb:   srcA = memWb.wbData;
            default: srcA = idEx.rsData;
        endcase
        case (forwardB)
            FwdMem:  srcBReg = exMem.aluResult;
            FwdWb:   srcBReg = memWb.wbData;
            default: srcBReg = idEx.rtData;
        endcase
    end

    assign srcB = idEx.aluSrcImm ? idEx.imm : srcBReg;

    aluUnit alu0 (
        .op     (idEx.aluOp),
        .srcA   (srcA),
        .srcB   (srcB),
        .result (exMemIn.aluResult)
    );

    // store data is the forwarded rt, not the immediate
    assign exMemIn.storeData = srcBReg;
    assign exMemIn.destReg   = idEx.destReg;
    assign exMemIn.regWrite  = idEx.regWrite;
    assign exMemIn.memRead   = idEx.memRead;
    assign exMemIn.memWrite  = idEx.memWrite;
    assign exMemIn.pc        = idEx.pc;

    stageReg #(.payloadT(exMemT)) exMemReg (
        .clk    (clk),
        .reset  (reset),
        .enable (!stallAll),
        .flush  (1'b0),
        .d      (exMemIn),
        .q      (exMem)
    );

    // memory, word accesses only
    assign addr      = exMem.aluResult;
    assign writeData = exMem.storeData;
    assign memEn     = exMem.memRead | exMem.memWrite;
    assign memWen    = {4{exMem.memWrite}};

    assign memWbIn.wbData   = exMem.memRead ? readData : exMem.aluResult;
    assign memWbIn.destReg  = exMem.destReg;
    assign memWbIn.regWrite = exMem.regWrite;
    assign memWbIn.pc       = exMem.pc;

    stageReg #(.payloadT(memWbT)) memWbReg (
        .clk    (clk),
        .reset  (reset),
        .enable (!stallAll),
        .flush  (1'b0),
        .d      (memWbIn),
        .q      (memWb)
    );

    // writeback debug trace
    assign debugWbPc      = memWb.pc;
    assign debugWbRfWen   = {4{rfWriteEn}};
    assign debugWbRfWnum  = memWb.destReg;
    assign debugWbRfWdata = memWb.wbData;

endmodule

/* testbench/pipeCore_props.sv */
`timescale 1ns/1ps

module pipeCore_props (
    input logic       clk,
    input logic       reset,
    input logic       memEn,
    input logic [3:0] memWen,
    input logic       stallAll,
    input logic [3:0] debugWbRfWen
);

    // failures so far, the testbench polls this
    int violations = 0;

    // store strobes only with the port enabled
    memWenNeedsEn: assert property (@(posedge clk) disable iff (reset)
        (memWen != 4'h0) |-> memEn)
        else begin
            $error("memWen active while memEn is low");
            violations++;
        end

    // no register write retires during a stall
    noWriteWhileStalled: assert property (@(posedge clk) disable iff (reset)
        stallAll |-> (debugWbRfWen == 4'h0))
        else begin
            $error("debugWbRfWen set while stallAll is high");
            violations++;
        end

    memIdleAfterReset: assert property (@(posedge clk) reset |=> !memEn)
        else begin
            $error("memEn high in the cycle after reset");
            violations++;
        end

endmodule

bind pipeCore pipeCore_props props0 (
    .clk          (clk),
    .reset        (reset),
    .memEn        (memEn),
    .memWen       (memWen),
    .stallAll     (stallAll),
    .debugWbRfWen (debugWbRfWen)
);

/* testbench/pipeCore_tb.sv */
`timescale 1ns/1ps

module pipeCore_tb;
    import mipsPkg::*;

    localparam wordT ResetPc  = 32'hbfc00000;
    localparam int   MemWords = 256;
    localparam int   Timeout  = 2000;

    logic       clk;
    logic       reset;
    wordT       pc;
    logic       instEn;
    wordT       inst;
    logic       iStall;
    wordT       addr;
    wordT       writeData;
    wordT       readData;
    logic [3:0] memWen;
    logic       memEn;
    logic       dStall;
    logic       stallAll;
    wordT       debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddrT    debugWbRfWnum;
    wordT       debugWbRfWdata;

    wordT        imem [MemWords];
    wordT        dmem [MemWords];
    wordT        refMem [MemWords];
    wordT        refRegs [32];
    wordT        expPc [$];
    regAddrT     expNum [$];
    wordT        expData [$];
    int          progLen;
    logic        stallMode;
    logic [31:0] lfsrState;
    wordT        fetchOffset;

    pipeCore #(.ResetPc(ResetPc)) dut0 (
        .clk            (clk),
        .reset          (reset),
        .pc             (pc),
        .instEn         (instEn),
        .inst           (inst),
        .iStall         (iStall),
        .addr           (addr),
        .writeData      (writeData),
        .readData       (readData),
        .memWen         (memWen),
        .memEn          (memEn),
        .dStall         (dStall),
        .stallAll       (stallAll),
        .debugWbPc      (debugWbPc),
        .debugWbRfWen   (debugWbRfWen),
        .debugWbRfWnum  (debugWbRfWnum),
        .debugWbRfWdata (debugWbRfWdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction memory returns junk ADDU r1 while fetch is stalled
    assign fetchOffset = pc - ResetPc;
    assign inst = iStall ? 32'h00210821 :
                  (fetchOffset[31:10] != '0) ? 32'h00000000 : imem[fetchOffset[9:2]];

    // data memory is refilled while reset is high
    assign readData = dmem[addr[9:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MemWords; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (memEn && memWen == 4'hf) begin
            dmem[addr[9:2]] <= writeData;
        end
    end

    function automatic wordT fillWord(input int idx);
        return (wordT'(idx) * 32'h9e3779b9) ^ 32'h0badf00d;
    endfunction

    // Galois LFSR stepped once per bit
    function automatic logic takeBit();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return lsb;
    endfunction

    function automatic wordT takeBits(input int n);
        wordT value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], takeBit()};
        end
        return value;
    endfunction

    function automatic wordT rTypeWord(input logic [5:0] fn, input regAddrT rd,
                                       input regAddrT rs, input regAddrT rt);
        return {OpSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT iTypeWord(input logic [5:0] op, input regAddrT rt,
                                       input regAddrT rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input string testName, input string what,
                             input wordT expected, input wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s %s: expected %h, actual %h",
                               testName, what, expected, actual));
        end
    endtask

    task automatic checkReg(input string testName, input string what,
                            input regAddrT expected, input regAddrT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s %s: expected %0d, actual %0d",
                               testName, what, expected, actual));
        end
    endtask

    // reference model executes one instruction in program order
    task automatic modelInstruction(input wordT word, input wordT atPc);
        logic [5:0] op;
        logic [5:0] fn;
        regAddrT    dest;
        wordT       a;
        wordT       b;
        wordT       seImm;
        wordT       ea;
        wordT       value;
        logic       writes;
        op     = word[31:26];
        fn     = word[5:0];
        a      = refRegs[word[25:21]];
        b      = refRegs[word[20:16]];
        seImm  = {{16{word[15]}}, word[15:0]};
        ea     = a + seImm;
        dest   = word[20:16];
        value  = '0;
        writes = 1'b1;
        case (op)
            OpSpecial: begin
                dest = word[15:11];
                case (fn)
                    FnAddu:  value = a + b;
                    FnSubu:  value = a - b;
                    FnAnd:   value = a & b;
                    FnOr:    value = a | b;
                    FnXor:   value = a ^ b;
                    FnSlt:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            OpAddiu: value = a + seImm;
            OpOri:   value = a | {16'h0000, word[15:0]};
            OpLui:   value = {word[15:0], 16'h0000};
            OpLw:    value = refMem[ea[9:2]];
            OpSw: begin
                refMem[ea[9:2]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != 5'd0) begin
            refRegs[dest] = value;
            expPc.push_back(atPc);
            expNum.push_back(dest);
            expData.push_back(value);
        end
    endtask

    task automatic emit(input wordT word);
        wordT atPc;
        atPc = ResetPc + (wordT'(progLen) << 2);
        imem[progLen] = word;
        modelInstruction(word, atPc);
        progLen++;
    endtask

    task automatic loadConst(input regAddrT r, input wordT value);
        emit(iTypeWord(OpLui, r, 5'd0, value[31:16]));
        emit(iTypeWord(OpOri, r, r, value[15:0]));
    endtask

    task automatic startTest();
        @(negedge clk);
        reset     = 1'b1;
        iStall    = 1'b0;
        dStall    = 1'b0;
        stallMode = 1'b0;
        progLen   = 0;
        expPc.delete();
        expNum.delete();
        expData.delete();
        for (int i = 0; i < MemWords; i++) begin
            imem[i]   = '0;
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
    endtask

    task automatic driveStalls();
        if (stallMode) begin
            iStall = (takeBits(2) == 32'd0);
            dStall = (takeBits(2) == 32'd0);
        end else begin
            iStall = 1'b0;
            dStall = 1'b0;
        end
    endtask

    // looks at the write that lands on the next rising edge
    task automatic sampleWriteback(input string testName);
        if (dut0.props0.violations != 0) begin
            abortRun("an assertion in pipeCore_props failed");
        end else if (debugWbRfWen != 4'h0) begin
            if (debugWbRfWen != 4'hf) begin
                abortRun("debug write enable is only partly set");
            end else if (stallAll) begin
                abortRun("debug write reported while the pipeline is stalled");
            end else if (expPc.size() == 0) begin
                abortRun($sformatf("%s: unexpected register write from pc %h",
                                   testName, debugWbPc));
            end
            checkWord(testName, "debugWbPc", expPc.pop_front(), debugWbPc);
            checkReg(testName, "debugWbRfWnum", expNum.pop_front(), debugWbRfWnum);
            checkWord(testName, "debugWbRfWdata", expData.pop_front(), debugWbRfWdata);
        end
    endtask

    task automatic runProgram(input string testName);
        int cycles;
        cycles = 0;
        repeat (3) @(negedge clk);
        // state at the end of reset
        checkWord(testName, "pc", ResetPc, pc);
        if (instEn !== 1'b1) begin
            abortRun($sformatf("%s: instEn is low after reset", testName));
        end else if (memEn !== 1'b0 || debugWbRfWen !== 4'h0) begin
            abortRun($sformatf("%s: memory or debug write enable active in reset",
                               testName));
        end
        reset = 1'b0;
        while (expPc.size() != 0) begin
            @(negedge clk);
            driveStalls();
            #1;
            sampleWriteback(testName);
            cycles++;
            if (cycles > Timeout) begin
                abortRun($sformatf("%s: timed out with %0d register writes still missing",
                                   testName, expPc.size()));
            end
        end
        // nothing else may retire with a write while draining
        stallMode = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            driveStalls();
            #1;
            sampleWriteback(testName);
        end
        for (int i = 0; i < MemWords; i++) begin
            checkWord(testName, $sformatf("dmem[%0d]", i), refMem[i], dmem[i]);
        end
        $display("%s finished after %0d cycles", testName, cycles);
    endtask

    task automatic aluOpsTest();
        startTest();
        for (int r = 1; r <= 6; r++) begin
            loadConst(regAddrT'(r), takeBits(32));
        end
        emit(rTypeWord(FnAddu, 5'd7, 5'd1, 5'd2));
        emit(rTypeWord(FnSubu, 5'd8, 5'd3, 5'd4));
        emit(rTypeWord(FnAnd, 5'd9, 5'd5, 5'd6));
        emit(rTypeWord(FnOr, 5'd10, 5'd1, 5'd4));
        emit(rTypeWord(FnXor, 5'd11, 5'd2, 5'd5));
        emit(rTypeWord(FnSlt, 5'd12, 5'd3, 5'd6));
        emit(rTypeWord(FnSlt, 5'd13, 5'd6, 5'd3));
        emit(iTypeWord(OpAddiu, 5'd14, 5'd4, 16'h8001));
        emit(iTypeWord(OpAddiu, 5'd15, 5'd5, 16'h7ffe));
        emit(iTypeWord(OpOri, 5'd16, 5'd6, 16'hf00f));
        runProgram("aluOps");
    endtask

    task automatic forwardingTest();
        startTest();
        loadConst(5'd1, takeBits(32));
        loadConst(5'd2, takeBits(32));
        emit(rTypeWord(FnAddu, 5'd3, 5'd1, 5'd2));
        emit(rTypeWord(FnSubu, 5'd4, 5'd3, 5'd1));
        emit(rTypeWord(FnXor, 5'd5, 5'd3, 5'd4));
        // r3 three back comes through the register file bypass
        emit(rTypeWord(FnOr, 5'd6, 5'd3, 5'd0));
        emit(rTypeWord(FnAnd, 5'd7, 5'd4, 5'd5));
        emit(iTypeWord(OpAddiu, 5'd8, 5'd0, 16'h0001));
        emit(iTypeWord(OpAddiu, 5'd8, 5'd8, 16'h0002));
        // newer r8 in memory must beat the older one in writeback
        emit(rTypeWord(FnAddu, 5'd9, 5'd8, 5'd8));
        emit(rTypeWord(FnSlt, 5'd10, 5'd9, 5'd7));
        runProgram("forwarding");
    endtask

    task automatic loadUseTest();
        startTest();
        loadConst(5'd1, takeBits(32));
        emit(iTypeWord(OpOri, 5'd10, 5'd0, 16'h0040));
        emit(iTypeWord(OpSw, 5'd1, 5'd10, 16'h0008));
        emit(iTypeWord(OpLw, 5'd2, 5'd10, 16'h0008));
        emit(rTypeWord(FnAddu, 5'd3, 5'd2, 5'd2));
        emit(iTypeWord(OpLw, 5'd4, 5'd10, 16'h000c));
        emit(rTypeWord(FnSubu, 5'd5, 5'd1, 5'd4));
        emit(iTypeWord(OpSw, 5'd5, 5'd10, 16'hfffc));
        emit(iTypeWord(OpLw, 5'd6, 5'd10, 16'hfffc));
        // loaded value feeds a store right away
        emit(iTypeWord(OpSw, 5'd6, 5'd10, 16'h0010));
        emit(iTypeWord(OpLw, 5'd7, 5'd10, 16'h0010));
        emit(rTypeWord(FnXor, 5'd8, 5'd7, 5'd3));
        runProgram("loadUse");
    endtask

    task automatic stallTest();
        wordT offset;
        startTest();
        loadConst(5'd1, takeBits(32));
        loadConst(5'd2, takeBits(32));
        emit(iTypeWord(OpOri, 5'd10, 5'd0, 16'h0080));
        for (int i = 0; i < 6; i++) begin
            offset = takeBits(16);
            emit(rTypeWord(FnAddu, 5'd3, 5'd1, 5'd2));
            emit(iTypeWord(OpSw, 5'd3, 5'd10, 16'h0000));
            emit(iTypeWord(OpLw, 5'd4, 5'd10, 16'h0000));
            emit(rTypeWord(FnXor, 5'd1, 5'd4, 5'd2));
            emit(iTypeWord(OpAddiu, 5'd2, 5'd1, offset[15:0]));
            emit(iTypeWord(OpAddiu, 5'd10, 5'd10, 16'h0004));
        end
        stallMode = 1'b1;
        runProgram("stall");
    endtask

    task automatic zeroRegTest();
        startTest();
        loadConst(5'd1, takeBits(32));
        emit(rTypeWord(FnAddu, 5'd0, 5'd1, 5'd1));
        emit(iTypeWord(OpOri, 5'd0, 5'd1, 16'hffff));
        emit(iTypeWord(OpLui, 5'd0, 5'd0, 16'h1234));
        emit(iTypeWord(OpLw, 5'd0, 5'd0, 16'h0020));
        // opcode 0x3f, SPECIAL funct 0 and ADDI are all outside the subset
        emit(32'hfc221800);
        emit(rTypeWord(6'h00, 5'd2, 5'd1, 5'd1));
        emit(iTypeWord(6'h08, 5'd3, 5'd1, 16'h0001));
        emit(rTypeWord(FnAddu, 5'd4, 5'd0, 5'd1));
        emit(rTypeWord(FnOr, 5'd5, 5'd0, 5'd0));
        emit(iTypeWord(OpAddiu, 5'd6, 5'd0, 16'h0000));
        runProgram("zeroReg");
    endtask

    initial begin
        reset     = 1'b1;
        iStall    = 1'b0;
        dStall    = 1'b0;
        stallMode = 1'b0;
        progLen   = 0;
        lfsrState = 32'hf07b;
        aluOpsTest();
        forwardingTest();
        loadUseTest();
        stallTest();
        zeroRegTest();
        if (dut0.props0.violations == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

/* pipeCore.f */
rtl/mipsPkg.sv
rtl/stageReg.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/aluUnit.sv
rtl/pipeCore.sv
testbench/pipeCore_props.sv
testbench/pipeCore_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pipeCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pipeCore.f --top-module pipeCore_tb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/simv +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
